// ==== source/lfsr_pkg.sv ====
////////////////////////////////////////////////////////////
// LFSR widths, word and length types, reset seed and
// size of the per-length tap tables
////////////////////////////////////////////////////////////

package lfsr_pkg;

    ////////////////////////////////////////////////////////////
    // widths

    localparam int LFSR_WIDTH = 32;  // full shift register
    localparam int LEN_WIDTH  = 5;   // length selector, 0..31

    // one table row per encodable length
    localparam int TABLE_SIZE = 2 ** LEN_WIDTH;

    ////////////////////////////////////////////////////////////
    // types

    // register value, also used for tap masks
    typedef logic [LFSR_WIDTH-1:0] lfsr_word_t;

    // selected register length
    typedef logic [LEN_WIDTH-1:0] lfsr_len_t;

    ////////////////////////////////////////////////////////////
    // reset state

    // nonzero seed so that a valid length starts a sequence
    localparam lfsr_word_t LFSR_SEED = lfsr_word_t'(1);

endpackage

// ==== source/pin_pkg.sv ====
////////////////////////////////////////////////////////////
// pin group type and bit positions of the pin fields
////////////////////////////////////////////////////////////

package pin_pkg;

    // one 8-bit pin group
    typedef logic [7:0] pin_byte_t;

    ////////////////////////////////////////////////////////////
    // ui_in fields

    localparam int PIN_HOLD   = 7;  // 1 = single-step mode
    localparam int PIN_STEP   = 6;  // step button
    localparam int PIN_N_TAPS = 5;  // 1 = 4-tap polynomial

    // length field
    localparam int PIN_LEN_MSB = 4;
    localparam int PIN_LEN_LSB = 0;

    ////////////////////////////////////////////////////////////
    // output fields

    // uio_out carries valid on top, value bits 14..8 below it
    localparam int PIN_VALID = 7;

    // value bits spread over uo_out and uio_out
    localparam int SHOWN_BITS = 15;

endpackage

// ==== source/lfsr_if.sv ====
////////////////////////////////////////////////////////////
// link between the front panel and the LFSR core
////////////////////////////////////////////////////////////

interface lfsr_if;

    lfsr_pkg::lfsr_len_t  length;   // selected register length
    logic                 n_taps;   // 1 selects the 4-tap table
    logic                 advance;  // per-cycle shift enable
    lfsr_pkg::lfsr_word_t value;
    logic                 valid;    // low after an invalid length

    // front panel side
    modport panel (
        output length, n_taps, advance,
        input  value, valid
    );

    // LFSR core side
    modport core (
        input  length, n_taps, advance,
        output value, valid
    );

endinterface

// ==== source/lfsr_tap_table.sv ====
////////////////////////////////////////////////////////////
// feedback tap masks per length, 2-tap and 4-tap tables
////////////////////////////////////////////////////////////

module lfsr_tap_table (
    input  lfsr_pkg::lfsr_len_t  length,
    input  logic                 n_taps,
    output lfsr_pkg::lfsr_word_t mask,
    output logic                 mask_valid
);

    lfsr_pkg::lfsr_word_t            mask_2tap [lfsr_pkg::TABLE_SIZE];
    lfsr_pkg::lfsr_word_t            mask_4tap [lfsr_pkg::TABLE_SIZE];
    logic [lfsr_pkg::TABLE_SIZE-1:0] ok_2tap;  // bit n set when length n has a mask
    logic [lfsr_pkg::TABLE_SIZE-1:0] ok_4tap;

    ////////////////////////////////////////////////////////////
    // 2-tap polynomials, row index is the length

    assign mask_2tap = '{
        32'h0000_0000,  // 0
        32'h0000_0000,
        32'h0000_0003,  // 2
        32'h0000_0006,
        32'h0000_000C,  // 4
        32'h0000_0014,
        32'h0000_0030,
        32'h0000_0060,
        32'h0000_0000,  // 8, no 2-tap form
        32'h0000_0110,
        32'h0000_0240,
        32'h0000_0500,
        32'h0000_0000,  // 12 to 14 have none either
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_6000,
        32'h0000_0000,  // 16
        32'h0001_2000,
        32'h0002_0400,
        32'h0000_0000,
        32'h0009_0000,  // 20
        32'h0014_0000,
        32'h0030_0000,
        32'h0042_0000,
        32'h0000_0000,  // 24
        32'h0120_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0900_0000,  // 28
        32'h1400_0000,
        32'h0000_0000,
        32'h4800_0000
    };

    assign ok_2tap = 32'hB2F6_8EFC;

    ////////////////////////////////////////////////////////////
    // 4-tap polynomials, nothing below length 5

    assign mask_4tap = '{
        32'h0000_0000,  // 0
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,  // 4
        32'h0000_001E,
        32'h0000_0036,
        32'h0000_0078,
        32'h0000_00B8,  // 8
        32'h0000_01B0,
        32'h0000_0360,
        32'h0000_0740,
        32'h0000_0CA0,  // 12
        32'h0000_1B00,
        32'h0000_3500,
        32'h0000_7400,
        32'h0000_B400,  // 16
        32'h0001_E000,
        32'h0003_9000,
        32'h0007_2000,
        32'h000C_A000,  // 20
        32'h001C_8000,
        32'h0027_0000,
        32'h006A_0000,
        32'h00D8_0000,  // 24
        32'h01E0_0000,
        32'h0388_0000,
        32'h0720_0000,
        32'h0CA0_0000,  // 28
        32'h1D00_0000,
        32'h3280_0000,
        32'h7800_0000
    };

    assign ok_4tap = 32'hFFFF_FFE0;

    ////////////////////////////////////////////////////////////
    // row select

    assign mask       = n_taps ? mask_4tap[length] : mask_2tap[length];
    assign mask_valid = n_taps ? ok_4tap[length]   : ok_2tap[length];

endmodule

// ==== source/lfsr_fibonacci.sv ====
////////////////////////////////////////////////////////////
// Fibonacci LFSR core with parity feedback and invalid
// length handling
////////////////////////////////////////////////////////////

module lfsr_fibonacci (
    input logic  clk,
    input logic  rst_n,
    lfsr_if.core bus
);

    lfsr_pkg::lfsr_word_t mask;
    logic                 mask_valid;
    lfsr_pkg::lfsr_word_t value_q;
    logic                 valid_q;

    lfsr_tap_table tap_table0 (
        .length     (bus.length),
        .n_taps     (bus.n_taps),
        .mask       (mask),
        .mask_valid (mask_valid)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            value_q <= lfsr_pkg::LFSR_SEED;
            valid_q <= 1'b1;
        end else if (bus.advance) begin
            if (!mask_valid) begin
                // no polynomial for this length, drop to zero
                value_q <= '0;
                valid_q <= 1'b0;
            end else begin
                // shift up, parity of tapped bits into bit 0
                value_q <= {value_q[lfsr_pkg::LFSR_WIDTH-2:0], ^(value_q & mask)};
                valid_q <= 1'b1;
            end
        end
    end

    assign bus.value = value_q;
    assign bus.valid = valid_q;

    ////////////////////////////////////////////////////////////
    // checks

    // invalid state is always the all-zero word
    a_invalid_is_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !valid_q |-> (value_q == '0)
    ) else $error("lfsr invalid with nonzero value %h", value_q);

    // panel hold must freeze the register
    a_hold_freezes: assert property (
        @(posedge clk) disable iff (!rst_n)
        !bus.advance |=> $stable(value_q)
    ) else $error("lfsr value moved without advance");

endmodule

// ==== source/lfsr_panel.sv ====
////////////////////////////////////////////////////////////
// pin decode, run/step advance control and registered
// value and valid pins
////////////////////////////////////////////////////////////

module lfsr_panel (
    input  logic               clk,
    input  logic               rst_n,
    input  pin_pkg::pin_byte_t ui_in,
    output pin_pkg::pin_byte_t uo_out,
    output pin_pkg::pin_byte_t uio_out,
    lfsr_if.panel              bus
);

    logic                           hold;
    logic                           step;
    logic                           step_q;  // step as seen last cycle
    logic [pin_pkg::SHOWN_BITS-1:0] shown;

    ////////////////////////////////////////////////////////////
    // input decode

    assign hold       = ui_in[pin_pkg::PIN_HOLD];
    assign step       = ui_in[pin_pkg::PIN_STEP];
    assign bus.n_taps = ui_in[pin_pkg::PIN_N_TAPS];
    assign bus.length = ui_in[pin_pkg::PIN_LEN_MSB:pin_pkg::PIN_LEN_LSB];

    ////////////////////////////////////////////////////////////
    // advance control

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q <= 1'b0;
        end else begin
            step_q <= step;
        end
    end

    // run freely, or once per rising step while held
    assign bus.advance = !hold || (step && !step_q);

    ////////////////////////////////////////////////////////////
    // output pins

    assign shown = bus.value[pin_pkg::SHOWN_BITS-1:0];

    // loads with the core, so pins lag by one advance
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uo_out  <= '0;
            uio_out <= '0;
        end else if (bus.advance) begin
            uo_out                          <= shown[7:0];
            uio_out[pin_pkg::PIN_VALID]     <= bus.valid;
            uio_out[pin_pkg::PIN_VALID-1:0] <= shown[pin_pkg::SHOWN_BITS-1:8];
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    // one step press gives a single advance
    a_single_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        (hold && bus.advance) |=> !(hold && bus.advance)
    ) else $error("two advances in a row while in step mode");

endmodule

// ==== source/lfsr_top.sv ====
////////////////////////////////////////////////////////////
// LFSR top level, pin ports to panel and core
////////////////////////////////////////////////////////////

module lfsr_top (
    input  logic               clk,
    input  logic               rst_n,
    input  pin_pkg::pin_byte_t ui_in,    // hold, step, n_taps, length
    output pin_pkg::pin_byte_t uo_out,   // value 7..0
    output pin_pkg::pin_byte_t uio_out   // valid, value 14..8
);

    lfsr_if lfsr_bus ();

    ////////////////////////////////////////////////////////////
    // front panel

    lfsr_panel panel0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .bus     (lfsr_bus.panel)
    );

    ////////////////////////////////////////////////////////////
    // shift register core

    lfsr_fibonacci core0 (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (lfsr_bus.core)
    );

endmodule

// ==== test/tb_lfsr_top.sv ====
////////////////////////////////////////////////////////////
// directed testbench for the LFSR top level, with a
// reference model, value check task and watchdog
////////////////////////////////////////////////////////////

module tb_lfsr_top;

    localparam int CLK_PERIOD         = 20;
    localparam int RESET_CYCLES       = 16;
    localparam int RUN2_CYCLES        = 40;
    localparam int RUN4_CYCLES        = 300;
    localparam int STEP_RANDOM_CYCLES = 100;
    localparam int DIRECTED_CYCLES    = 80;   // short directed sequences
    localparam int PLANNED_CYCLES     = 3 * RESET_CYCLES + RUN2_CYCLES + RUN4_CYCLES
                                        + STEP_RANDOM_CYCLES + DIRECTED_CYCLES;

    logic               clk;
    logic               rst_n;
    pin_pkg::pin_byte_t ui_in;
    pin_pkg::pin_byte_t uo_out;
    pin_pkg::pin_byte_t uio_out;

    // reference model state
    logic [31:0] m_value;
    logic        m_valid;
    logic        m_step_q;
    logic [7:0]  m_uo;
    logic [7:0]  m_uio;

    integer seed = 4;

    lfsr_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_out (uio_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // reference model

    // {valid, mask} for the rows this testbench selects
    function automatic logic [32:0] model_row(input logic [4:0] len, input logic four_taps);
        if (!four_taps && len == 5'd4) begin
            return {1'b1, 32'h0000_000C};  // x^4 + x^3
        end else if (four_taps && len == 5'd8) begin
            return {1'b1, 32'h0000_00B8};  // x^8 + x^6 + x^5 + x^4
        end
        return {1'b0, 32'h0};               // 2-tap 8, 4-tap 3
    endfunction

    function automatic logic [7:0] make_ui(input logic hold, input logic step,
                                           input logic four_taps, input logic [4:0] len);
        return {hold, step, four_taps, len};
    endfunction

    // one rising edge of the model, from the inputs driven before it
    task automatic model_edge();
        logic        advance;
        logic [32:0] row;
        if (!rst_n) begin
            m_value  = 32'h1;
            m_valid  = 1'b1;
            m_step_q = 1'b0;
            m_uo     = 8'h00;
            m_uio    = 8'h00;
        end else begin
            advance  = !ui_in[7] || (ui_in[6] && !m_step_q);
            m_step_q = ui_in[6];
            if (advance) begin
                m_uo  = m_value[7:0];      // pins show the pre-edge state
                m_uio = {m_valid, m_value[14:8]};
                row   = model_row(ui_in[4:0], ui_in[5]);
                if (!row[32]) begin
                    m_value = 32'h0;
                    m_valid = 1'b0;
                end else begin
                    m_value = {m_value[30:0], ^(m_value & row[31:0])};
                    m_valid = 1'b1;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // helpers

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (expected %h, got %h)",
                     $time, msg, expected, actual);
            $display("Verification failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_pins(input string msg);
        check_equal(uo_out, m_uo, {msg, ": uo_out"});
        check_equal(uio_out, m_uio, {msg, ": uio_out"});
    endtask

    // rising edge into the model, then back to the falling edge
    task automatic run_cycle();
        @(posedge clk);
        model_edge();
        @(negedge clk);
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) run_cycle();
        rst_n = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // tests

    task automatic test_reset();
        check_equal(uo_out, 8'h00, "uo_out after reset");
        check_equal(uio_out, 8'h00, "uio_out after reset");
        ui_in = make_ui(1'b0, 1'b0, 1'b0, 5'd4);
        run_cycle();
        check_equal(uo_out, 8'h01, "seed on uo_out");
        check_equal(uio_out, 8'h80, "valid on uio_out");
        check_pins("first advance");
        ui_in = make_ui(1'b1, 1'b0, 1'b0, 5'd4);
    endtask

    task automatic test_run_two_tap();
        integer since;
        integer hits;
        since = (uo_out[3:0] == 4'h1) ? 0 : -1;
        hits  = 0;
        ui_in = make_ui(1'b0, 1'b0, 1'b0, 5'd4);
        for (int i = 0; i < RUN2_CYCLES; i++) begin
            run_cycle();
            check_pins("2-tap run");
            if (since >= 0) since = since + 1;
            if (uo_out[3:0] == 4'h1) begin
                if (since >= 0) check_equal(since, 15, "2-tap period of low nibble");
                since = 0;
                hits  = hits + 1;
            end
        end
        check_equal(hits >= 2, 1'b1, "low nibble returned to 1 at least twice");
    endtask

    task automatic test_run_four_tap();
        logic [7:0] hist [RUN4_CYCLES];
        integer     first_repeat;
        first_repeat = 0;
        ui_in = make_ui(1'b0, 1'b0, 1'b1, 5'd8);
        for (int i = 0; i < RUN4_CYCLES; i++) begin
            run_cycle();
            check_pins("4-tap run");
            hist[i] = uo_out;
        end
        for (int j = 1; j < RUN4_CYCLES; j++) begin
            if (first_repeat == 0 && hist[j] == hist[0]) first_repeat = j;
        end
        check_equal(first_repeat, 255, "4-tap period of low byte");
        for (int i = 255; i < RUN4_CYCLES; i++) begin
            check_equal(hist[i], hist[i-255], "4-tap sequence repeat");
        end
    endtask

    task automatic test_invalid_length();
        ui_in = make_ui(1'b0, 1'b0, 1'b0, 5'd8);  // no 2-tap row for 8
        run_cycle();
        check_pins("2-tap length 8, first edge");
        check_equal(uio_out[7], 1'b1, "valid still shown one edge later");
        run_cycle();
        check_equal({uio_out, uo_out}, 16'h0, "pins zero after 2-tap length 8");
        check_pins("2-tap length 8, second edge");
        ui_in = make_ui(1'b0, 1'b0, 1'b0, 5'd4);
        repeat (20) begin
            run_cycle();
            // valid comes back, the value does not
            check_equal({uio_out[6:0], uo_out}, 15'h0, "zero kept at valid length");
            check_pins("stuck at zero");
        end
        apply_reset();
        ui_in = make_ui(1'b0, 1'b0, 1'b1, 5'd3);  // 4-tap starts at 5
        run_cycle();
        check_pins("4-tap length 3, first edge");
        run_cycle();
        check_equal({uio_out, uo_out}, 16'h0, "pins zero after 4-tap length 3");
        ui_in = make_ui(1'b0, 1'b0, 1'b1, 5'd8);
        repeat (10) begin
            run_cycle();
            check_equal({uio_out[6:0], uo_out}, 15'h0, "zero kept at 4-tap length 8");
            check_pins("stuck at zero, 4 taps");
        end
        ui_in = make_ui(1'b1, 1'b0, 1'b1, 5'd8);
        apply_reset();
    endtask

    task automatic test_single_step();
        logic [15:0] snapshot;
        integer      r;
        snapshot = {uio_out, uo_out};
        repeat (5) begin
            run_cycle();
            check_equal({uio_out, uo_out}, snapshot, "frozen with step low");
        end
        for (int p = 0; p < 4; p++) begin
            ui_in = make_ui(1'b1, 1'b1, 1'b1, 5'd8);
            run_cycle();
            // seed walks up one bit per press, taps give 0
            check_equal(uo_out, 8'h01 << p, "value after step press");
            check_equal(uio_out, 8'h80, "valid after step press");
            check_pins("step press");
            snapshot = {uio_out, uo_out};
            repeat (3) begin
                run_cycle();
                check_equal({uio_out, uo_out}, snapshot, "frozen with step high");
            end
            ui_in = make_ui(1'b1, 1'b0, 1'b1, 5'd8);
            run_cycle();
            check_equal({uio_out, uo_out}, snapshot, "frozen after step release");
        end
        for (int i = 0; i < STEP_RANDOM_CYCLES; i++) begin
            r     = $random(seed);
            ui_in = make_ui(1'b1, r[0], 1'b1, 5'd8);
            run_cycle();
            check_pins("random step pattern");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        ui_in = make_ui(1'b1, 1'b0, 1'b0, 5'd4);
        apply_reset();
        test_reset();
        test_run_two_tap();
        test_run_four_tap();
        test_invalid_length();
        test_single_step();
        $display("Verification passed");
        $finish;
    end

    // watchdog
    initial begin
        #((PLANNED_CYCLES + 200) * CLK_PERIOD);
        $display("ERROR: simulation timed out before the tests finished");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== sim.f ====
source/lfsr_pkg.sv
source/pin_pkg.sv
source/lfsr_if.sv
source/lfsr_tap_table.sv
source/lfsr_fibonacci.sv
source/lfsr_panel.sv
source/lfsr_top.sv
test/tb_lfsr_top.sv

// ==== Makefile ====
# Verilator build and run for the LFSR project

VERILATOR ?= verilator
TOP       ?= tb_lfsr_top
RTL_TOP   ?= lfsr_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Verification passed
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides pass or fail, the exit code of tee does not
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
